// ==== rtl/bus_settings.svh ====
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// number of agents sharing the bus
`define BUS_DRIVERS 4

// full word width
`define BUS_WIDTH 16

// destination field, taken from the top bits of a word
`define BUS_ID_WIDTH 8

// reaches every agent except the sender
`define BUS_BROADCAST {`BUS_ID_WIDTH{1'b1}}

`endif

// ==== rtl/bus_types_pkg.sv ====
`include "bus_settings.svh"

package bus_types_pkg;

  // one word as it travels on the bus
  typedef logic [`BUS_WIDTH-1:0] word_t;

  // destination id in the top bits of a word
  typedef logic [`BUS_ID_WIDTH-1:0] dest_t;

  // keep at least one bit even for a single agent
  localparam int agent_bits = (`BUS_DRIVERS > 1) ? $clog2(`BUS_DRIVERS) : 1;

  // agent index, also the value of the turn register
  typedef logic [agent_bits-1:0] agent_t;

endpackage

// ==== rtl/bus_ctrl_pkg.sv ====
package bus_ctrl_pkg;

  // transmit side of one agent
  //   tx_idle  wait for the turn
  //   tx_pop   take a word from the queue
  //   tx_drive put it on the bus and hand the turn on
  typedef enum logic [1:0] {
    tx_idle,
    tx_pop,
    tx_drive
  } tx_state_t;

endpackage

// ==== rtl/agent_bus_if.sv ====
`timescale 1ns/1ps

interface agent_bus_if;
  import bus_types_pkg::*;

  // this agent holds the turn
  logic  grant;
  // one-cycle pulse, hand the turn to the next agent
  logic  pass;
  // data carries a valid word this cycle
  logic  wrt;
  word_t data;

  modport tx (
    input  grant,
    output pass,
    output wrt,
    output data
  );

  modport ctrl (
    output grant,
    input  pass,
    input  wrt,
    input  data
  );
endinterface

// ==== rtl/turn_ctrl.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module turn_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  agent_bus_if.ctrl             links [`BUS_DRIVERS],
  output logic                  bus_wrt,
  output bus_types_pkg::word_t  bus_data,
  output bus_types_pkg::agent_t holder
);
  import bus_types_pkg::*;

  localparam agent_t last_agent = agent_t'(`BUS_DRIVERS - 1);

  agent_t                  turn;
  logic [`BUS_DRIVERS-1:0] pass_vec;
  logic [`BUS_DRIVERS-1:0] wrt_vec;
  word_t                   data_vec [`BUS_DRIVERS];

  ////////////////////////////////////////////////////////////
  // per-agent links
  ////////////////////////////////////////////////////////////

  // grants decode straight from the turn register
  // strobes and words are gathered for the bus select
  for (genvar i = 0; i < `BUS_DRIVERS; i++) begin : g_link
    assign links[i].grant = (turn == agent_t'(i));
    assign pass_vec[i]    = links[i].pass;
    assign wrt_vec[i]     = links[i].wrt;
    assign data_vec[i]    = links[i].data;
  end

  ////////////////////////////////////////////////////////////
  // round-robin turn
  ////////////////////////////////////////////////////////////

  // only the holder's pass moves the turn
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      turn <= '0;
    end else if (pass_vec[turn]) begin
      if (turn == last_agent) begin
        turn <= '0;
      end else begin
        turn <= turn + agent_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // shared bus
  ////////////////////////////////////////////////////////////

  // mux on the turn register drives the shared bus
  assign holder   = turn;
  assign bus_wrt  = wrt_vec[turn];
  assign bus_data = data_vec[turn];

endmodule

// ==== rtl/agent_tx.sv ====
`timescale 1ns/1ps

module agent_tx (
  input  logic                 clk,
  input  logic                 rst,
  agent_bus_if.tx              link,
  input  logic                 pndng,
  input  bus_types_pkg::word_t d_pop,
  output logic                 pop
);
  import bus_types_pkg::*;
  import bus_ctrl_pkg::*;

  tx_state_t state;
  tx_state_t state_nxt;
  word_t     word_q;
  logic      empty_turn;

  ////////////////////////////////////////////////////////////
  // transmit FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      tx_idle: begin
        // start only while holding the turn
        if (link.grant && pndng) begin
          state_nxt = tx_pop;
        end
      end
      tx_pop: begin
        state_nxt = tx_drive;
      end
      tx_drive: begin
        // turn moves on at this edge
        state_nxt = tx_idle;
      end
      default: begin
        state_nxt = tx_idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= tx_idle;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // outgoing word
  ////////////////////////////////////////////////////////////

  // queue head is valid with pndng, taken as pop closes
  always_ff @(posedge clk) begin
    if (state == tx_pop) begin
      word_q <= d_pop;
    end
  end

  // holder with nothing queued gives the turn away at once
  assign empty_turn = (state == tx_idle) && link.grant && !pndng;

  assign pop       = (state == tx_pop);
  assign link.wrt  = (state == tx_drive);
  assign link.data = word_q;
  assign link.pass = (state == tx_drive) || empty_turn;

endmodule

// ==== rtl/agent_rx.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module agent_rx #(
  parameter bus_types_pkg::agent_t ID = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  bus_wrt,
  input  bus_types_pkg::word_t  bus_data,
  input  bus_types_pkg::agent_t holder,
  output logic                  push,
  output bus_types_pkg::word_t  d_push
);
  import bus_types_pkg::*;

  dest_t dest;
  logic  dest_hit;
  logic  take;

  // destination sits in the top bits of the word
  assign dest = bus_data[`BUS_WIDTH-1 -: `BUS_ID_WIDTH];

  assign dest_hit = (dest == dest_t'(ID)) || (dest == `BUS_BROADCAST);

  // the sender never receives its own word, broadcast included
  assign take = bus_wrt && (holder != ID) && dest_hit;

  // push is a single-cycle strobe after the bus write
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      push   <= 1'b0;
      d_push <= '0;
    end else begin
      push <= take;
      // last received word stays until the next one
      if (take) begin
        d_push <= bus_data;
      end
    end
  end

endmodule

// ==== rtl/prll_bus.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module prll_bus (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`BUS_DRIVERS-1:0] pndng,
  input  bus_types_pkg::word_t    d_pop  [`BUS_DRIVERS],
  output logic [`BUS_DRIVERS-1:0] pop,
  output logic [`BUS_DRIVERS-1:0] push,
  output bus_types_pkg::word_t    d_push [`BUS_DRIVERS]
);
  import bus_types_pkg::*;

  // shared bus as seen by every receiver
  logic   bus_wrt;
  word_t  bus_data;
  agent_t holder;

  // one link per agent between its transmitter and the turn controller
  agent_bus_if links [`BUS_DRIVERS] ();

  ////////////////////////////////////////////////////////////
  // turn controller
  ////////////////////////////////////////////////////////////

  turn_ctrl u_turn_ctrl (
    .clk      (clk),
    .rst      (rst),
    .links    (links),
    .bus_wrt  (bus_wrt),
    .bus_data (bus_data),
    .holder   (holder)
  );

  ////////////////////////////////////////////////////////////
  // agents
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `BUS_DRIVERS; i++) begin : g_agent
    agent_tx u_tx (
      .clk   (clk),
      .rst   (rst),
      .link  (links[i]),
      .pndng (pndng[i]),
      .d_pop (d_pop[i]),
      .pop   (pop[i])
    );

    // receiver id equals its position in the loop
    agent_rx #(
      .ID (agent_t'(i))
    ) u_rx (
      .clk      (clk),
      .rst      (rst),
      .bus_wrt  (bus_wrt),
      .bus_data (bus_data),
      .holder   (holder),
      .push     (push[i]),
      .d_push   (d_push[i])
    );
  end

endmodule

// ==== test/prll_bus_assert.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module prll_bus_assert (
  input  logic                    clk,
  input  logic                    rst,
  agent_bus_if.ctrl               links [`BUS_DRIVERS],
  input  logic [`BUS_DRIVERS-1:0] pass_vec,
  input  logic [`BUS_DRIVERS-1:0] wrt_vec,
  input  bus_types_pkg::agent_t   turn,
  input  logic                    bus_wrt
);
  import bus_types_pkg::*;

  logic [`BUS_DRIVERS-1:0] grant_vec;
  int                      fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  for (genvar i = 0; i < `BUS_DRIVERS; i++) begin : g_grant
    assign grant_vec[i] = links[i].grant;
  end

  // a pass may only come from the single granted agent
  a_one_grant : assert property (@(posedge clk) disable iff (rst)
    $onehot(grant_vec) && ((pass_vec & ~grant_vec) == '0))
    else begin
      $error("grants %b not one-hot or pass %b from an agent without grant",
             grant_vec, pass_vec);
      fail_cnt++;
    end

  // turn only moves when the holder passes it
  a_turn_hold : assert property (@(posedge clk) disable iff (rst)
    !pass_vec[turn] |=> (turn == $past(turn)))
    else begin
      $error("turn moved without a pass from the holder");
      fail_cnt++;
    end

  a_turn_step : assert property (@(posedge clk) disable iff (rst)
    pass_vec[turn] |=> (int'(turn) == (int'($past(turn)) + 1) % `BUS_DRIVERS))
    else begin
      $error("turn did not advance to the next agent after a pass");
      fail_cnt++;
    end

  a_bus_holder : assert property (@(posedge clk) disable iff (rst)
    ((wrt_vec & ~grant_vec) == '0) && (bus_wrt == |wrt_vec))
    else begin
      $error("bus write does not come from the holder");
      fail_cnt++;
    end

endmodule

bind turn_ctrl prll_bus_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .links    (links),
  .pass_vec (pass_vec),
  .wrt_vec  (wrt_vec),
  .turn     (turn),
  .bus_wrt  (bus_wrt)
);

// ==== test/prll_bus_checker.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module prll_bus_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`BUS_DRIVERS-1:0] pndng,
  input  logic [`BUS_DRIVERS-1:0] pop,
  input  bus_types_pkg::word_t    d_pop  [`BUS_DRIVERS],
  input  logic [`BUS_DRIVERS-1:0] push,
  input  bus_types_pkg::word_t    d_push [`BUS_DRIVERS],
  output int                      mismatch_cnt,
  output int                      other_cnt,
  output int                      pending_cnt,
  output int                      push_cnt
);
  import bus_types_pkg::*;

  // one push that some agent still owes
  typedef struct packed {
    int    due;
    int    dst;
    word_t word;
  } expect_t;

  expect_t expq [$];
  int      cycle;
  int      next_src;
  logic    all_pend;

  initial begin
    mismatch_cnt = 0;
    other_cnt    = 0;
    pending_cnt  = 0;
    push_cnt     = 0;
  end

  // delivery rule: never the sender, else broadcast or own id
  function automatic logic should_receive(int src, int dst, dest_t dest);
    if (dst == src) begin
      return 1'b0;
    end
    return (dest == `BUS_BROADCAST) || (int'(dest) == dst);
  endfunction

  ////////////////////////////////////////////////////////////
  // sampled mid-cycle, all ports settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin : watch
    dest_t   dest;
    int      hit;
    expect_t e;
    if (rst) begin
      cycle    = 0;
      next_src = 0;
      all_pend = 1'b1;
      expq.delete();
      if (pop != '0 || push != '0) begin
        $display("error at %0t: pop or push active during reset", $time);
        other_cnt++;
      end
      for (int k = 0; k < `BUS_DRIVERS; k++) begin
        if (d_push[k] != '0) begin
          $display("MISMATCH at %0t: agent %0d d_push %h in reset, expected 0",
                   $time, k, d_push[k]);
          mismatch_cnt++;
        end
      end
    end else begin
      cycle++;
      if ($countones(pop) > 1) begin
        $display("error at %0t: more than one agent pops in the same cycle", $time);
        other_cnt++;
      end
      // order is only known while every queue stays loaded
      if (pndng != '1) begin
        all_pend = 1'b0;
      end
      for (int i = 0; i < `BUS_DRIVERS; i++) begin
        if (pop[i]) begin
          if (all_pend && i != next_src) begin
            $display("error at %0t: agent %0d popped out of round-robin order, expected %0d",
                     $time, i, next_src);
            other_cnt++;
          end
          next_src = (i + 1) % `BUS_DRIVERS;
          all_pend = 1'b1;
          dest     = d_pop[i][`BUS_WIDTH-1 -: `BUS_ID_WIDTH];
          for (int k = 0; k < `BUS_DRIVERS; k++) begin
            if (should_receive(i, k, dest)) begin
              e.due  = cycle + 2;
              e.dst  = k;
              e.word = d_pop[i];
              expq.push_back(e);
            end
          end
        end
      end
      for (int k = 0; k < `BUS_DRIVERS; k++) begin
        if (push[k]) begin
          push_cnt++;
          hit = -1;
          for (int j = 0; j < expq.size(); j++) begin
            if (hit < 0 && expq[j].dst == k && expq[j].due == cycle) begin
              hit = j;
            end
          end
          if (hit < 0) begin
            $display("error at %0t: agent %0d pushed %h with no matching pop two cycles before",
                     $time, k, d_push[k]);
            other_cnt++;
          end else begin
            if (d_push[k] != expq[hit].word) begin
              $display("MISMATCH at %0t: agent %0d d_push %h, expected %h",
                       $time, k, d_push[k], expq[hit].word);
              mismatch_cnt++;
            end
            expq.delete(hit);
          end
        end
      end
      // anything still due now was never pushed
      for (int j = expq.size() - 1; j >= 0; j--) begin
        if (expq[j].due <= cycle) begin
          $display("error at %0t: agent %0d never received word %h",
                   $time, expq[j].dst, expq[j].word);
          other_cnt++;
          expq.delete(j);
        end
      end
    end
    pending_cnt = expq.size();
  end

endmodule

// ==== test/prll_bus_tb.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module prll_bus_tb;
  import bus_types_pkg::*;

  typedef logic [`BUS_WIDTH-`BUS_ID_WIDTH-1:0] payload_t;

  // mask holds the agents that must receive the word
  typedef struct packed {
    agent_t                  src;
    dest_t                   dest;
    payload_t                payload;
    logic [`BUS_DRIVERS-1:0] mask;
  } row_t;

  localparam int n_directed   = 12;
  localparam int n_random     = 40;
  localparam int n_rows       = n_directed + n_random;
  localparam int limit_cycles = n_rows * 3 * `BUS_DRIVERS + 200;

  logic                    clk;
  logic                    rst;
  logic [`BUS_DRIVERS-1:0] pndng;
  logic [`BUS_DRIVERS-1:0] pop;
  logic [`BUS_DRIVERS-1:0] push;
  word_t                   d_pop  [`BUS_DRIVERS];
  word_t                   d_push [`BUS_DRIVERS];
  int                      mismatch_cnt;
  int                      other_cnt;
  int                      pending_cnt;
  int                      push_cnt;

  row_t  rows [n_rows];
  int    n_filled;
  int    exp_pushes;
  word_t queues [`BUS_DRIVERS][$];

  prll_bus prll_bus_i (
    .clk    (clk),
    .rst    (rst),
    .pndng  (pndng),
    .d_pop  (d_pop),
    .pop    (pop),
    .push   (push),
    .d_push (d_push)
  );

  prll_bus_checker checker_i (
    .clk          (clk),
    .rst          (rst),
    .pndng        (pndng),
    .pop          (pop),
    .d_pop        (d_pop),
    .push         (push),
    .d_push       (d_push),
    .mismatch_cnt (mismatch_cnt),
    .other_cnt    (other_cnt),
    .pending_cnt  (pending_cnt),
    .push_cnt     (push_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the queues did not drain within %0d cycles", limit_cycles);
    $display("Errors found");
    $finish;
  end

  task automatic add_row(int src, dest_t dest, payload_t payload,
                         logic [`BUS_DRIVERS-1:0] mask);
    rows[n_filled] = '{agent_t'(src), dest, payload, mask};
    n_filled++;
  endtask

  function automatic logic [`BUS_DRIVERS-1:0] receivers(int src, dest_t dest);
    logic [`BUS_DRIVERS-1:0] m;
    m = '0;
    for (int k = 0; k < `BUS_DRIVERS; k++) begin
      if (k != src && (dest == `BUS_BROADCAST || int'(dest) == k)) begin
        m[k] = 1'b1;
      end
    end
    return m;
  endfunction

  // queue heads fall through onto d_pop
  task automatic drive_inputs();
    for (int i = 0; i < `BUS_DRIVERS; i++) begin
      pndng[i] = (queues[i].size() != 0);
      d_pop[i] = (queues[i].size() != 0) ? queues[i][0] : '0;
    end
  endtask

  function automatic logic all_drained();
    for (int i = 0; i < `BUS_DRIVERS; i++) begin
      if (queues[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  initial begin : main
    logic [`BUS_DRIVERS-1:0] taken;
    logic                    done;
    int                      src;
    dest_t                   dest;
    int                      assert_cnt;
    int                      count_err;
    rst        = 1'b1;
    pndng      = '0;
    n_filled   = 0;
    exp_pushes = 0;
    count_err  = 0;
    done       = 1'b0;
    for (int i = 0; i < `BUS_DRIVERS; i++) begin
      d_pop[i] = '0;
    end
    void'($urandom(32'h90b00568));

    // every agent gets a row so all queues start loaded
    add_row(0, 8'h01, 8'h11, 4'b0010);
    add_row(1, 8'h02, 8'h22, 4'b0100);
    add_row(2, 8'h03, 8'h33, 4'b1000);
    add_row(3, 8'h00, 8'h44, 4'b0001);
    add_row(0, 8'hff, 8'h55, 4'b1110);
    add_row(1, 8'h01, 8'h66, 4'b0000);
    add_row(2, 8'h10, 8'h77, 4'b0000);
    add_row(3, 8'hff, 8'h88, 4'b0111);
    add_row(1, 8'h04, 8'h99, 4'b0000);
    add_row(2, 8'h00, 8'haa, 4'b0001);
    add_row(0, 8'h03, 8'hbb, 4'b1000);
    add_row(3, 8'h03, 8'hcc, 4'b0000);
    for (int r = 0; r < n_random; r++) begin
      src  = int'($urandom_range(`BUS_DRIVERS - 1));
      dest = ($urandom_range(4) == 0) ? `BUS_BROADCAST : dest_t'($urandom_range(`BUS_DRIVERS + 1));
      add_row(src, dest, payload_t'($urandom()), receivers(src, dest));
    end

    for (int r = 0; r < n_rows; r++) begin
      queues[rows[r].src].push_back({rows[r].dest, rows[r].payload});
      exp_pushes += $countones(rows[r].mask);
    end
    drive_inputs();
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    while (!done) begin
      @(negedge clk);
      taken = pop;
      @(posedge clk);
      #2;
      for (int i = 0; i < `BUS_DRIVERS; i++) begin
        if (taken[i]) begin
          void'(queues[i].pop_front());
        end
      end
      drive_inputs();
      done = all_drained() && (pending_cnt == 0);
    end
    // stray pushes after the last delivery still get caught
    repeat (4) @(negedge clk);

    assert_cnt = prll_bus_i.u_turn_ctrl.u_assert.fail_cnt;
    if (push_cnt != exp_pushes) begin
      $display("error: %0d pushes seen, the stimulus table expects %0d", push_cnt, exp_pushes);
      count_err++;
    end
    $display("mismatches %0d, delivery errors %0d, assertion failures %0d, count errors %0d",
             mismatch_cnt, other_cnt, assert_cnt, count_err);
    if (mismatch_cnt + other_cnt + assert_cnt + count_err == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== prll_bus.f ====
+incdir+rtl
rtl/bus_types_pkg.sv
rtl/bus_ctrl_pkg.sv
rtl/agent_bus_if.sv
rtl/turn_ctrl.sv
rtl/agent_tx.sv
rtl/agent_rx.sv
rtl/prll_bus.sv
test/prll_bus_assert.sv
test/prll_bus_checker.sv
test/prll_bus_tb.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= prll_bus_tb
FILELIST    ?= prll_bus.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
